// File: logic/ext_pps_monitor.sv
`timescale 1ns/1ps

module ext_pps_monitor import t2mi_pps_pkg::*; #(
    parameter int ticks_per_second = 100_000_000
) (
    input  logic clk_100mhz,
    input  logic rst_n_sync,
    input  logic ext_pps_in,
    output logic ext_pulse,      // Three cycles after the input edge
    output logic ext_pps_locked
);

    localparam ticks_t period_lo = ticks_t'(ticks_per_second - ext_tolerance_ticks);
    localparam ticks_t period_hi = ticks_t'(ticks_per_second + ext_tolerance_ticks);

    logic   sync_ff1, sync_ff2, sync_ff3; // Two-flop sync + previous level
    ticks_t period_cnt;                   // Cycles since last edge
    logic   have_ref;                     // A previous edge is known
    logic   good_once;                    // One good period seen
    logic   period_ok;

    assign period_ok = (period_cnt >= period_lo) && (period_cnt <= period_hi);

    // ========================================================================
    // Synchronizer and edge register
    // ========================================================================
    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            sync_ff1  <= 1'b0;
            sync_ff2  <= 1'b0;
            sync_ff3  <= 1'b0;
            ext_pulse <= 1'b0;
        end else begin
            sync_ff1  <= ext_pps_in;
            sync_ff2  <= sync_ff1;
            sync_ff3  <= sync_ff2;
            ext_pulse <= sync_ff2 && !sync_ff3; // Rising edge
        end
    end

    // ========================================================================
    // Period check and lock
    // ========================================================================
    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            period_cnt     <= '0;
            have_ref       <= 1'b0;
            good_once      <= 1'b0;
            ext_pps_locked <= 1'b0;
        end else if (ext_pulse) begin
            period_cnt <= ticks_t'(1);
            have_ref   <= 1'b1;
            if (have_ref && period_ok) begin
                if (good_once) ext_pps_locked <= 1'b1; // Second good period
                good_once <= 1'b1;
            end else if (have_ref) begin
                good_once      <= 1'b0; // Off-period edge
                ext_pps_locked <= 1'b0;
            end
        end else if (have_ref) begin
            if (period_cnt > period_hi) begin
                have_ref       <= 1'b0; // Edge missing, start over
                good_once      <= 1'b0;
                ext_pps_locked <= 1'b0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/pps_source_select.sv
`timescale 1ns/1ps

module pps_source_select import t2mi_pps_pkg::*; (
    input  logic        clk_100mhz,
    input  logic        rst_n_sync,
    input  logic        time_valid,
    input  logic        sync_locked,
    input  logic        ext_pps_locked,
    input  logic        t2mi_pps,
    input  logic        ext_pulse,
    output logic        pps_out,
    output pps_source_t active_source
);

    // Priority choice, T2-MI first
    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            active_source <= src_none;
        end else if (time_valid && sync_locked) begin
            active_source <= src_t2mi;
        end else if (ext_pps_locked) begin
            active_source <= src_ext; // Fallback
        end else begin
            active_source <= src_none;
        end
    end

    // Pulse of the registered source
    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            pps_out <= 1'b0;
        end else begin
            case (active_source)
                src_t2mi: pps_out <= t2mi_pps;
                src_ext:  pps_out <= ext_pulse;
                default:  pps_out <= 1'b0; // No usable source
            endcase
        end
    end

endmodule

// File: logic/status_leds.sv
`timescale 1ns/1ps

module status_leds import t2mi_pps_pkg::*; (
    input  logic        clk_100mhz,
    input  logic        rst_n_sync,
    input  logic        sync_locked,
    input  logic        pps_out,
    input  err_count_t  error_count,
    input  pps_source_t active_source,
    input  logic        ext_pps_locked,
    output logic        led_sync,
    output logic        led_pps,
    output logic        led_error,
    output logic        led_ext_pps
);

    logic [7:0] stretch_cnt; // PPS activity stretch

    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            stretch_cnt <= '0;
        end else if (pps_out) begin
            stretch_cnt <= 8'(led_stretch_cycles); // Retrigger
        end else if (stretch_cnt != '0) begin
            stretch_cnt <= stretch_cnt - 1'b1;
        end
    end

    assign led_pps     = (stretch_cnt != '0);
    assign led_error   = (error_count != '0) || (active_source == src_ext); // Errors or fallback
    assign led_sync    = sync_locked;
    assign led_ext_pps = ext_pps_locked;

endmodule

// File: logic/t2mi_packet_parser.sv
`timescale 1ns/1ps

module t2mi_packet_parser import t2mi_pps_pkg::*; (
    input  logic          clk_100mhz,
    input  logic          rst_n_sync,
    input  logic          t2mi_valid,
    input  byte_t         t2mi_data,
    input  logic          t2mi_sync,   // First header byte
    output payload_beat_t beat,
    output logic          sync_locked,
    output err_count_t    error_count
);

    typedef enum logic [1:0] {st_idle, st_header, st_payload, st_crc} parser_state_t;

    parser_state_t  state;
    payload_index_t byte_cnt;     // Position inside current section
    payload_index_t payload_len;  // Payload bytes, rounded up from bits
    byte_t          pkt_type;
    byte_t          len_hi;
    logic [1:0]     lock_cnt;     // Consecutive complete packets
    logic [16:0]    len_round;    // Bit length + 7
    logic           last_payload;

    assign len_round    = {1'b0, len_hi, t2mi_data} + 17'd7;
    assign last_payload = (byte_cnt == payload_len - 1'b1);

    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            state       <= st_idle;
            byte_cnt    <= '0;
            payload_len <= '0;
            pkt_type    <= '0;
            len_hi      <= '0;
            lock_cnt    <= '0;
            sync_locked <= 1'b0;
            error_count <= '0;
            beat        <= '0;
        end else begin
            beat.valid <= 1'b0; // Single-cycle beat
            beat.last  <= 1'b0;
            if (t2mi_valid && t2mi_sync) begin
                // Sync before the packet ended counts as an error
                if (state != st_idle) begin
                    if (error_count != '1) error_count <= error_count + 1'b1; // Saturate
                    sync_locked <= 1'b0;
                    lock_cnt    <= '0;
                end
                pkt_type <= t2mi_data; // Header byte 0
                byte_cnt <= payload_index_t'(1);
                state    <= st_header;
            end else if (t2mi_valid) begin
                case (state)
                    st_header: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == payload_index_t'(4)) len_hi <= t2mi_data;
                        if (byte_cnt == payload_index_t'(header_bytes - 1)) begin
                            payload_len <= {2'b00, len_round[16:3]};
                            byte_cnt    <= '0;
                            state       <= (len_round[16:3] == '0) ? st_crc : st_payload;
                        end
                    end
                    st_payload: begin
                        beat.valid       <= 1'b1;
                        beat.packet_type <= pkt_type;
                        beat.index       <= byte_cnt;
                        beat.data        <= t2mi_data;
                        beat.last        <= last_payload;
                        byte_cnt         <= byte_cnt + 1'b1;
                        if (last_payload) begin
                            byte_cnt <= '0;
                            state    <= st_crc;
                        end
                    end
                    st_crc: begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == payload_index_t'(crc_bytes - 1)) begin
                            state <= st_idle; // Packet complete
                            if (lock_cnt == 2'(lock_packet_count - 1)) sync_locked <= 1'b1;
                            else lock_cnt <= lock_cnt + 1'b1;
                        end
                    end
                    default: ; // Hunting, bytes without sync dropped
                endcase
            end
        end
    end

endmodule

// File: logic/t2mi_pps_pkg.sv
package t2mi_pps_pkg;

    // ========================================================================
    // Stream and packet constants
    // ========================================================================
    localparam logic [7:0] timestamp_packet_type = 8'h20; // T2-MI timestamp packet
    localparam int header_bytes            = 6;  // Type, count, sframe, rsvd, len hi, len lo
    localparam int crc_bytes               = 4;  // Trailing CRC, skipped
    localparam int timestamp_payload_bytes = 11; // Bw + 5 seconds + 5 subsec/utco
    localparam int lock_packet_count       = 2;  // Good packets before sync lock
    localparam int ext_tolerance_ticks     = 16; // Ext PPS period window, +/- ticks
    localparam int led_stretch_cycles      = 255;

    // Widths with a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [39:0] seconds_t;       // Seconds since 2000
    typedef logic [26:0] ticks_t;         // 10 ns clock ticks
    typedef logic [26:0] delay_t;
    typedef logic [7:0]  err_count_t;
    typedef logic [15:0] payload_index_t;

    // One payload byte from the parser
    typedef struct packed {
        logic           valid;
        byte_t          packet_type;
        payload_index_t index;
        byte_t          data;
        logic           last;
    } payload_beat_t;

    // Decoded timestamp, valid for one cycle
    typedef struct packed {
        logic     valid;
        seconds_t seconds;
        ticks_t   subseconds;
    } timestamp_t;

    typedef enum logic [1:0] {src_none, src_t2mi, src_ext} pps_source_t;

endpackage

// File: logic/t2mi_pps_top.sv
`timescale 1ns/1ps

module t2mi_pps_top import t2mi_pps_pkg::*; #(
    parameter int ticks_per_second = 100_000_000
) (
    input  logic        clk_100mhz,
    input  logic        rst_n_sync,        // Already synchronized
    input  logic        t2mi_valid,
    input  byte_t       t2mi_data,
    input  logic        t2mi_sync,
    input  logic        ext_pps_in,
    input  delay_t      cable_delay,       // Static, in ticks
    input  delay_t      antenna_delay,
    output logic        pps_out,
    output seconds_t    time_seconds,
    output ticks_t      time_subseconds,
    output logic        time_valid,
    output logic        sync_locked,
    output logic        ext_pps_locked,
    output pps_source_t active_source,
    output err_count_t  parser_error_count,
    output logic        led_sync,
    output logic        led_pps,
    output logic        led_error,
    output logic        led_ext_pps
);

    payload_beat_t beat;
    timestamp_t    stamp;
    logic          t2mi_pps;  // Counter wrap pulse
    logic          ext_pulse; // Qualified external edge

    // ========================================================================
    // T2-MI path
    // ========================================================================
    t2mi_packet_parser u_t2mi_packet_parser (
        .clk_100mhz  (clk_100mhz),
        .rst_n_sync  (rst_n_sync),
        .t2mi_valid  (t2mi_valid),
        .t2mi_data   (t2mi_data),
        .t2mi_sync   (t2mi_sync),
        .beat        (beat),
        .sync_locked (sync_locked),
        .error_count (parser_error_count)
    );

    timestamp_extractor u_timestamp_extractor (
        .clk_100mhz (clk_100mhz),
        .rst_n_sync (rst_n_sync),
        .beat       (beat),
        .stamp      (stamp)
    );

    time_of_day_counter #(.ticks_per_second(ticks_per_second)) u_time_of_day_counter (
        .clk_100mhz      (clk_100mhz),
        .rst_n_sync      (rst_n_sync),
        .stamp           (stamp),
        .cable_delay     (cable_delay),
        .antenna_delay   (antenna_delay),
        .time_seconds    (time_seconds),
        .time_subseconds (time_subseconds),
        .time_valid      (time_valid),
        .pps             (t2mi_pps)
    );

    // ========================================================================
    // External PPS, selection and LEDs
    // ========================================================================
    ext_pps_monitor #(.ticks_per_second(ticks_per_second)) u_ext_pps_monitor (
        .clk_100mhz     (clk_100mhz),
        .rst_n_sync     (rst_n_sync),
        .ext_pps_in     (ext_pps_in),
        .ext_pulse      (ext_pulse),
        .ext_pps_locked (ext_pps_locked)
    );

    pps_source_select u_pps_source_select (
        .clk_100mhz     (clk_100mhz),
        .rst_n_sync     (rst_n_sync),
        .time_valid     (time_valid),
        .sync_locked    (sync_locked),
        .ext_pps_locked (ext_pps_locked),
        .t2mi_pps       (t2mi_pps),
        .ext_pulse      (ext_pulse),
        .pps_out        (pps_out),
        .active_source  (active_source)
    );

    status_leds u_status_leds (
        .clk_100mhz     (clk_100mhz),
        .rst_n_sync     (rst_n_sync),
        .sync_locked    (sync_locked),
        .pps_out        (pps_out),
        .error_count    (parser_error_count),
        .active_source  (active_source),
        .ext_pps_locked (ext_pps_locked),
        .led_sync       (led_sync),
        .led_pps        (led_pps),
        .led_error      (led_error),
        .led_ext_pps    (led_ext_pps)
    );

endmodule

// File: logic/time_of_day_counter.sv
`timescale 1ns/1ps

module time_of_day_counter import t2mi_pps_pkg::*; #(
    parameter int ticks_per_second = 100_000_000
) (
    input  logic       clk_100mhz,
    input  logic       rst_n_sync,
    input  timestamp_t stamp,
    input  delay_t     cable_delay,
    input  delay_t     antenna_delay,
    output seconds_t   time_seconds,
    output ticks_t     time_subseconds,
    output logic       time_valid,
    output logic       pps          // High while subseconds show 0 after a wrap
);

    localparam logic [28:0] tps_w = 29'(ticks_per_second);

    logic [28:0] sum_ticks;  // Stamp ticks + both delays
    ticks_t      load_ticks;
    logic [1:0]  load_carry; // Delays below one second each
    logic        stamp_ok;

    assign sum_ticks = 29'(stamp.subseconds) + 29'(cable_delay) + 29'(antenna_delay);
    assign stamp_ok  = stamp.valid && (29'(stamp.subseconds) < tps_w);

    // Fold the sum back into one second
    always_comb begin
        if (sum_ticks >= {tps_w[27:0], 1'b0}) begin
            load_ticks = ticks_t'(sum_ticks - {tps_w[27:0], 1'b0});
            load_carry = 2'd2;
        end else if (sum_ticks >= tps_w) begin
            load_ticks = ticks_t'(sum_ticks - tps_w);
            load_carry = 2'd1;
        end else begin
            load_ticks = ticks_t'(sum_ticks);
            load_carry = 2'd0;
        end
    end

    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            time_seconds    <= '0;
            time_subseconds <= '0;
            time_valid      <= 1'b0;
            pps             <= 1'b0;
        end else if (stamp_ok) begin
            time_seconds    <= stamp.seconds + seconds_t'(load_carry);
            time_subseconds <= load_ticks;
            time_valid      <= 1'b1; // Sticky until reset
            pps             <= 1'b0; // No pulse on a load
        end else if (time_valid) begin
            if (time_subseconds == ticks_t'(ticks_per_second - 1)) begin
                time_subseconds <= '0;
                time_seconds    <= time_seconds + 1'b1;
                pps             <= 1'b1;
            end else begin
                time_subseconds <= time_subseconds + 1'b1;
                pps             <= 1'b0;
            end
        end
    end

endmodule

// File: logic/timestamp_extractor.sv
`timescale 1ns/1ps

module timestamp_extractor import t2mi_pps_pkg::*; (
    input  logic          clk_100mhz,
    input  logic          rst_n_sync,
    input  payload_beat_t beat,
    output timestamp_t    stamp
);

    seconds_t    sec_shift;   // Payload bytes 1..5, MSB first
    logic [39:0] frac_shift;  // Bytes 6..10, subsec[39:13], UTC offset[12:0]
    logic        stamp_valid;
    logic        is_ts;

    assign is_ts = beat.valid && (beat.packet_type == timestamp_packet_type);

    always_ff @(posedge clk_100mhz or negedge rst_n_sync) begin
        if (!rst_n_sync) begin
            stamp_valid <= 1'b0;
        end else begin
            // Short or long packets are discarded
            stamp_valid <= is_ts && beat.last &&
                           (beat.index == payload_index_t'(timestamp_payload_bytes - 1));
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (is_ts) begin
            if (beat.index == '0) begin
                // Bandwidth code, ticks do not depend on it
                sec_shift  <= '0;
                frac_shift <= '0;
            end else if (beat.index <= payload_index_t'(5)) begin
                sec_shift <= {sec_shift[31:0], beat.data};
            end else if (beat.index < payload_index_t'(timestamp_payload_bytes)) begin
                frac_shift <= {frac_shift[31:0], beat.data};
            end
        end
    end

    always_comb begin
        stamp.valid      = stamp_valid;
        stamp.seconds    = sec_shift;
        stamp.subseconds = frac_shift[39:13]; // UTC offset bits left out
    end

endmodule

// File: project.f
logic/t2mi_pps_pkg.sv
logic/t2mi_packet_parser.sv
logic/timestamp_extractor.sv
logic/time_of_day_counter.sv
logic/ext_pps_monitor.sv
logic/pps_source_select.sv
logic/status_leds.sv
logic/t2mi_pps_top.sv
testbench/t2mi_pps_tb.sv

// File: testbench/t2mi_pps_tb.sv
`timescale 1ns/1ps

module t2mi_pps_tb import t2mi_pps_pkg::*; ();

    localparam int clk_period       = 10;
    localparam int ticks_per_second = 1000;  // Short second for simulation
    localparam int packet_cycles    = 40;    // Longest packet plus gap
    localparam int ext_lock_limit   = 3500;  // Three ext edges plus sync delay
    localparam int observe_cycles   = 2100;  // Two PPS periods
    localparam int test_cycles      = 8 * packet_cycles + ext_lock_limit
                                      + 4 * observe_cycles + 20;
    localparam int watchdog_cycles  = test_cycles + test_cycles / 10;

    logic        clk_100mhz = 1'b0;
    logic        rst_n_sync;
    logic        t2mi_valid;
    byte_t       t2mi_data;
    logic        t2mi_sync;
    logic        ext_pps_in;
    delay_t      cable_delay;
    delay_t      antenna_delay;
    logic        pps_out;
    seconds_t    time_seconds;
    ticks_t      time_subseconds;
    logic        time_valid;
    logic        sync_locked;
    logic        ext_pps_locked;
    pps_source_t active_source;
    err_count_t  parser_error_count;
    logic        led_sync, led_pps, led_error, led_ext_pps;

    int          value_errors = 0;
    int          other_errors = 0;
    logic [31:0] lfsr_state   = 32'd86873;
    byte_t       payload_q[$];           // Payload of the next packet
    int          pkt_count    = 0;
    int          ext_edges    = 0;
    seconds_t    load_sec     = '0;      // Expected time after the load
    ticks_t      load_sub     = '0;

    // History for the checks, one cycle back unless noted
    ticks_t      prev_sub, prev2_sub;
    seconds_t    prev_sec;
    logic        prev_valid, prev_sync, prev_ext;
    pps_source_t prev_src;
    logic [4:0]  ext_hist  = '0;         // Bit i is ext_pps_in i+1 cycles back
    int          since_pps = 0;          // Cycles since last pps_out, 0 = none yet

    t2mi_pps_top #(.ticks_per_second(ticks_per_second)) u_t2mi_pps_top (
        .clk_100mhz         (clk_100mhz),
        .rst_n_sync         (rst_n_sync),
        .t2mi_valid         (t2mi_valid),
        .t2mi_data          (t2mi_data),
        .t2mi_sync          (t2mi_sync),
        .ext_pps_in         (ext_pps_in),
        .cable_delay        (cable_delay),
        .antenna_delay      (antenna_delay),
        .pps_out            (pps_out),
        .time_seconds       (time_seconds),
        .time_subseconds    (time_subseconds),
        .time_valid         (time_valid),
        .sync_locked        (sync_locked),
        .ext_pps_locked     (ext_pps_locked),
        .active_source      (active_source),
        .parser_error_count (parser_error_count),
        .led_sync           (led_sync),
        .led_pps            (led_pps),
        .led_error          (led_error),
        .led_ext_pps        (led_ext_pps)
    );

    always #(clk_period / 2) clk_100mhz = ~clk_100mhz;

    // ========================================================================
    // Reporting, random bits and expected-value rules
    // ========================================================================
    task automatic value_mismatch(input string name, input longint unsigned expected,
                                  input longint unsigned actual);
        value_errors++;
        $display("Fail at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic note_failure(input string what);
        other_errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic check_value(input string name, input longint unsigned expected,
                               input longint unsigned actual);
        assert (actual == expected) else value_mismatch(name, expected, actual);
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state); // One step per bit
            v          = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic ticks_t next_tick(input ticks_t t);
        return (t == ticks_t'(ticks_per_second - 1)) ? ticks_t'(0) : t + 1'b1;
    endfunction

    function automatic seconds_t next_second(input seconds_t s, input ticks_t t);
        return (t == ticks_t'(ticks_per_second - 1)) ? s + 1'b1 : s;
    endfunction

    // T2-MI wins, external PPS is the fallback
    function automatic pps_source_t pick_source(input logic valid, input logic locked,
                                                input logic ext);
        if (valid && locked) return src_t2mi;
        if (ext) return src_ext;
        return src_none;
    endfunction

    // ========================================================================
    // Stream driving
    // ========================================================================
    task automatic send_byte(input byte_t data, input logic sync);
        @(posedge clk_100mhz);
        #1;
        t2mi_valid = 1'b1;
        t2mi_data  = data;
        t2mi_sync  = sync;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_100mhz);
        #1;
        t2mi_valid = 1'b0;
        t2mi_sync  = 1'b0;
    endtask

    // Header, payload_q, CRC; abort_at >= 0 stops before that payload byte
    task automatic send_packet(input byte_t ptype, input int bit_len, input int abort_at);
        send_byte(ptype, 1'b1);
        send_byte(byte_t'(pkt_count), 1'b0);
        send_byte(8'h00, 1'b0);               // Superframe index
        send_byte(8'h00, 1'b0);               // Reserved
        send_byte(byte_t'(bit_len >> 8), 1'b0);
        send_byte(byte_t'(bit_len), 1'b0);
        pkt_count++;
        foreach (payload_q[i]) begin
            if (i == abort_at) return;        // Next sync cuts in here
            send_byte(payload_q[i], 1'b0);
        end
        repeat (crc_bytes) send_byte(byte_t'(take_bits(8)), 1'b0);
        idle_cycles(1);
    endtask

    // Baseband-frame type, random length, bit count not byte aligned
    task automatic send_filler();
        int n;
        n = 8 + int'(take_bits(4));
        payload_q.delete();
        repeat (n) payload_q.push_back(byte_t'(take_bits(8)));
        send_packet(8'h00, n * 8 - int'(take_bits(3)), -1);
    endtask

    task automatic fill_timestamp(input seconds_t s, input ticks_t sub, input int n);
        logic [39:0] frac;
        frac = {sub, 13'(take_bits(13))};     // Subseconds over UTC offset
        payload_q.delete();
        payload_q.push_back(byte_t'(take_bits(4))); // Bandwidth code
        for (int i = 4; i >= 0; i--) payload_q.push_back(s[i*8 +: 8]);
        for (int i = 4; i >= 0; i--) payload_q.push_back(frac[i*8 +: 8]);
        while (payload_q.size() > n) void'(payload_q.pop_back());
    endtask

    task automatic wait_for_source(input pps_source_t want, input int limit);
        int waited;
        waited = 0;
        while (active_source != want && waited < limit) begin
            @(posedge clk_100mhz);
            #1;
            waited++;
        end
        if (active_source != want)
            note_failure($sformatf("active_source did not reach %s within %0d cycles",
                                   want.name(), limit));
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    always @(posedge clk_100mhz) begin
        prev_sub   <= time_subseconds;
        prev2_sub  <= prev_sub;
        prev_sec   <= time_seconds;
        prev_valid <= time_valid;
        prev_sync  <= sync_locked;
        prev_ext   <= ext_pps_locked;
        prev_src   <= active_source;
        ext_hist   <= {ext_hist[3:0], ext_pps_in};
        if (pps_out) since_pps <= 1;
        else if (since_pps != 0 && since_pps < 1000) since_pps <= since_pps + 1;
    end

    tick_advance: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            prev_valid && time_valid |-> time_subseconds == next_tick(prev_sub))
        else value_mismatch("time_subseconds", next_tick($sampled(prev_sub)),
                            $sampled(time_subseconds));

    second_advance: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            prev_valid && time_valid |-> time_seconds == next_second(prev_sec, prev_sub))
        else value_mismatch("time_seconds", next_second($sampled(prev_sec),
                            $sampled(prev_sub)), $sampled(time_seconds));

    // First valid cycle shows stamp plus both delays
    load_seconds: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            time_valid && !prev_valid |-> time_seconds == load_sec)
        else value_mismatch("time_seconds", $sampled(load_sec), $sampled(time_seconds));

    load_ticks: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            time_valid && !prev_valid |-> time_subseconds == load_sub)
        else value_mismatch("time_subseconds", $sampled(load_sub),
                            $sampled(time_subseconds));

    source_choice: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            active_source == pick_source(prev_valid, prev_sync, prev_ext))
        else value_mismatch("active_source", pick_source($sampled(prev_valid),
                            $sampled(prev_sync), $sampled(prev_ext)), $sampled(active_source));

    // Wrap shown one cycle earlier, never a load
    t2mi_pps_timing: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            prev_src == src_t2mi |->
            pps_out == (prev_sub == '0 && prev2_sub == ticks_t'(ticks_per_second - 1)))
        else value_mismatch("pps_out", !$sampled(pps_out), $sampled(pps_out));

    ext_pps_timing: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            prev_src == src_ext |-> pps_out == (ext_hist[3] && !ext_hist[4]))
        else value_mismatch("pps_out", !$sampled(pps_out), $sampled(pps_out));

    no_source_quiet: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            prev_src == src_none |-> !pps_out)
        else value_mismatch("pps_out", 0, $sampled(pps_out));

    led_pps_stretch: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            since_pps != 0 |-> led_pps == (since_pps <= led_stretch_cycles))
        else value_mismatch("led_pps", !$sampled(led_pps), $sampled(led_pps));

    led_error_rule: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            led_error == (parser_error_count != '0 || active_source == src_ext))
        else value_mismatch("led_error", !$sampled(led_error), $sampled(led_error));

    led_sync_rule: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            led_sync == sync_locked)
        else value_mismatch("led_sync", $sampled(sync_locked), $sampled(led_sync));

    led_ext_rule: assert property (@(posedge clk_100mhz) disable iff (!rst_n_sync)
            led_ext_pps == ext_pps_locked)
        else value_mismatch("led_ext_pps", $sampled(ext_pps_locked), $sampled(led_ext_pps));

    // ========================================================================
    // Stimulus
    // ========================================================================
    // External PPS, exact 1000-cycle period
    initial begin
        wait (rst_n_sync === 1'b1);
        forever begin
            repeat (ticks_per_second - 10) @(posedge clk_100mhz);
            #1;
            ext_pps_in = 1'b1;
            ext_edges++;
            repeat (10) @(posedge clk_100mhz);
            #1;
            ext_pps_in = 1'b0;
        end
    end

    initial begin
        seconds_t ts_sec;
        ticks_t   ts_sub;
        int       total;
        rst_n_sync    = 1'b0;
        t2mi_valid    = 1'b0;
        t2mi_data     = '0;
        t2mi_sync     = 1'b0;
        ext_pps_in    = 1'b0;
        cable_delay   = '0;
        antenna_delay = '0;
        repeat (3) @(posedge clk_100mhz);
        #1;
        rst_n_sync = 1'b1;
        check_value("pps_out", 0, pps_out);
        check_value("time_valid", 0, time_valid);
        check_value("active_source", src_none, active_source);
        check_value("led_pps", 0, led_pps);

        // Parser lock after two packets
        send_filler();
        check_value("sync_locked", 0, sync_locked);
        send_filler();
        check_value("sync_locked", 1, sync_locked);

        // External fallback, no T2-MI time yet
        wait_for_source(src_ext, ext_lock_limit);
        check_value("ext_pps_in edges at lock", 3, ext_edges);
        check_value("time_valid", 0, time_valid);
        idle_cycles(observe_cycles);

        // Timestamp load with random delays
        ts_sec        = seconds_t'(take_bits(40));
        ts_sub        = ticks_t'(take_bits(10) % ticks_per_second);
        cable_delay   = delay_t'(take_bits(9) % 500);
        antenna_delay = delay_t'(take_bits(9) % 500);
        total         = int'(ts_sub) + int'(cable_delay) + int'(antenna_delay);
        load_sec      = ts_sec + seconds_t'(total / ticks_per_second);
        load_sub      = ticks_t'(total % ticks_per_second);
        fill_timestamp(ts_sec, ts_sub, timestamp_payload_bytes);
        send_packet(timestamp_packet_type, 88, -1);
        check_value("time_valid", 1, time_valid);
        wait_for_source(src_t2mi, 10);
        idle_cycles(observe_cycles);

        // Sync inside a timestamp packet
        fill_timestamp(seconds_t'(take_bits(40)), ticks_t'(take_bits(9)),
                       timestamp_payload_bytes);
        send_packet(timestamp_packet_type, 88, 6);
        send_filler();
        check_value("parser_error_count", 1, parser_error_count);
        check_value("sync_locked", 0, sync_locked);
        check_value("led_error", 1, led_error);
        idle_cycles(observe_cycles);

        // Short payload, then subseconds out of range
        fill_timestamp(seconds_t'(take_bits(40)), ticks_t'(take_bits(9)), 10);
        send_packet(timestamp_packet_type, 80, -1);
        fill_timestamp(seconds_t'(take_bits(40)),
                       ticks_t'(ticks_per_second + int'(take_bits(10))),
                       timestamp_payload_bytes);
        send_packet(timestamp_packet_type, 88, -1);
        idle_cycles(observe_cycles);
        check_value("time_valid", 1, time_valid);
        finish_run();
    end

    initial begin
        #(watchdog_cycles * clk_period);
        note_failure($sformatf("watchdog expired after %0d cycles", watchdog_cycles));
        finish_run();
    end

endmodule
